// ==== stc_params.svh ====
`ifndef STC_PARAMS_SVH
`define STC_PARAMS_SVH

//**********************************************************
// Widths
//**********************************************************
`define STC_ADDR_W      13      // Wishbone word address
`define STC_DATA_W      24
`define STC_SAMPLE_W    18
`define STC_ADC_W       14      // Offset binary from the ADC
`define STC_DAC_W       14      // Offset binary to the DAC
`define STC_PAD_W       4       // Zero bits below the ADC word

`define STC_VERSION     654

//**********************************************************
// Address map
//**********************************************************
`define STC_TOP_BASE    13'h000
`define STC_DAC0_BASE   13'h100
`define STC_DAC1_BASE   13'h110
`define STC_SPACE_MASK  13'h1F0

// Top space offsets
`define REG_VERSION     4'd0
`define REG_SCRATCH     4'd1
`define REG_STATUS      4'd2

// DAC space offsets, same in both channels
`define REG_SOURCE      4'd0
`define REG_TEST        4'd1

`endif

// ==== stcPkg.sv ====
`default_nettype none
`include "stc_params.svh"

package stcPkg;

    // One sample of a stream
    typedef struct packed {
        logic                               valid;
        logic signed [`STC_SAMPLE_W-1:0]    data;
    } sampleT;

    typedef enum logic [1:0] {
        spaceNone,
        spaceTop,
        spaceDac0,
        spaceDac1
    } regSpaceT;

    // Decoded bus cycle
    typedef struct packed {
        logic                       strobe;     // High on the cycle before ack
        logic                       write;
        regSpaceT                   space;
        logic [3:0]                 offset;
        logic [`STC_DATA_W-1:0]     data;
        logic [1:0]                 sel;        // Lane 0 is 15:0, lane 1 is 23:16
    } busAccessT;

    typedef enum logic [3:0] {
        srcTest  = 4'd0,
        srcDemod = 4'd1,
        srcStc   = 4'd2,
        srcAdc   = 4'd3
    } dacSourceT;

    // Settings for one DAC channel
    typedef struct packed {
        dacSourceT                          source;
        logic signed [`STC_SAMPLE_W-1:0]    testValue;
    } dacRegsT;

endpackage

`default_nettype wire

// ==== busDecode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "stc_params.svh"

module busDecode (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [`STC_ADDR_W-1:0]      wbAdr,
    input  logic [`STC_DATA_W-1:0]      wbDatW,
    input  logic [1:0]                  wbSel,
    output logic                        wbAck,
    output stcPkg::busAccessT           access
);

    import stcPkg::*;

    logic                       strobe;
    logic [`STC_ADDR_W-1:0]     maskedAdr;
    regSpaceT                   space;

    // One request per cycle of ack low
    assign strobe = wbCyc && wbStb && !wbAck;

    always_ff @(posedge clk) begin
        if (reset) begin
            wbAck <= 1'b0;
        end else begin
            wbAck <= strobe;    // Fixed one cycle latency
        end
    end

    //**********************************************************
    // Address space decode
    //**********************************************************
    assign maskedAdr = wbAdr & `STC_SPACE_MASK;

    always_comb begin
        case (maskedAdr)
            `STC_TOP_BASE:  space = spaceTop;
            `STC_DAC0_BASE: space = spaceDac0;
            `STC_DAC1_BASE: space = spaceDac1;
            default:        space = spaceNone;    // Acked, reads zero
        endcase
    end

    assign access = '{strobe: strobe, write: wbWe, space: space,
                      offset: wbAdr[3:0], data: wbDatW, sel: wbSel};

    ackSingle: assert property (@(posedge clk) disable iff (reset)
        wbAck |=> !wbAck);

    ackAfterRequest: assert property (@(posedge clk) disable iff (reset)
        wbAck |-> $past(wbCyc && wbStb));

endmodule

`default_nettype wire

// ==== configRegs.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "stc_params.svh"

module configRegs (
    input  logic                        clk,
    input  logic                        reset,
    input  stcPkg::busAccessT           access,
    input  logic                        pilotFound,
    input  logic                        pilotLocked,
    output logic [`STC_DATA_W-1:0]      topRead,
    output logic [`STC_DATA_W-1:0]      dac0Read,
    output logic [`STC_DATA_W-1:0]      dac1Read,
    output stcPkg::dacRegsT             dac0Regs,
    output stcPkg::dacRegsT             dac1Regs,
    output logic                        lockLed0n,
    output logic                        lockLed1n
);

    import stcPkg::*;

    logic [`STC_DATA_W-1:0]     scratch;
    dacRegsT                    dacRegs [2];
    logic [`STC_DATA_W-1:0]     dacRead [2];

    // Keep lanes whose sel bit is low
    function automatic logic [`STC_DATA_W-1:0] mergeLanes(
        input logic [`STC_DATA_W-1:0] oldWord,
        input logic [`STC_DATA_W-1:0] newWord,
        input logic [1:0]             sel
    );
        logic [`STC_DATA_W-1:0] merged;
        merged = oldWord;
        if (sel[0]) merged[15:0] = newWord[15:0];
        if (sel[1]) merged[23:16] = newWord[23:16];
        return merged;
    endfunction

    //**********************************************************
    // Top space
    //**********************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            scratch <= '0;
        end else if (access.strobe && access.write && access.space == spaceTop
                     && access.offset == `REG_SCRATCH) begin
            scratch <= mergeLanes(scratch, access.data, access.sel);
        end
    end

    always_comb begin
        case (access.offset)
            `REG_VERSION: topRead = `STC_DATA_W'(`STC_VERSION);
            `REG_SCRATCH: topRead = scratch;
            `REG_STATUS:  topRead = {{(`STC_DATA_W-2){1'b0}}, pilotLocked, pilotFound};
            default:      topRead = '0;
        endcase
    end

    //**********************************************************
    // DAC spaces
    //**********************************************************
    for (genvar ch = 0; ch < 2; ch++) begin : gDac
        localparam regSpaceT chSpace = (ch == 0) ? spaceDac0 : spaceDac1;

        logic                       dacWrite;
        logic [`STC_DATA_W-1:0]     srcWord;
        logic [`STC_DATA_W-1:0]     testWord;
        logic [`STC_DATA_W-1:0]     readWord;

        assign dacWrite = access.strobe && access.write && access.space == chSpace;
        assign srcWord  = mergeLanes({{(`STC_DATA_W-4){1'b0}}, dacRegs[ch].source},
                                     access.data, access.sel);
        assign testWord = mergeLanes(`STC_DATA_W'(dacRegs[ch].testValue),
                                     access.data, access.sel);

        always_ff @(posedge clk) begin
            if (reset) begin
                dacRegs[ch] <= '0;
            end else if (dacWrite) begin
                // Unknown source codes are dropped
                if (access.offset == `REG_SOURCE &&
                    srcWord[3:0] inside {srcTest, srcDemod, srcStc, srcAdc})
                    dacRegs[ch].source <= dacSourceT'(srcWord[3:0]);
                if (access.offset == `REG_TEST)
                    dacRegs[ch].testValue <= testWord[`STC_SAMPLE_W-1:0];
            end
        end

        always_comb begin
            case (access.offset)
                `REG_SOURCE: readWord = {{(`STC_DATA_W-4){1'b0}}, dacRegs[ch].source};
                `REG_TEST:   readWord = `STC_DATA_W'(dacRegs[ch].testValue);  // Sign extended
                default:     readWord = '0;
            endcase
        end
        assign dacRead[ch] = readWord;

        sourceLegal: assert property (@(posedge clk) disable iff (reset)
            dacRegs[ch].source inside {srcTest, srcDemod, srcStc, srcAdc});
    end

    assign dac0Read = dacRead[0];
    assign dac1Read = dacRead[1];
    assign dac0Regs = dacRegs[0];
    assign dac1Regs = dacRegs[1];

    assign lockLed0n = !pilotFound;     // LEDs are active low
    assign lockLed1n = !pilotLocked;

endmodule

`default_nettype wire

// ==== dacChannel.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "stc_params.svh"

module dacChannel (
    input  logic                        clk,
    input  logic                        reset,
    input  stcPkg::dacRegsT             regs,
    input  stcPkg::sampleT              demodSample,
    input  stcPkg::sampleT              stcSample,
    input  stcPkg::sampleT              adcSample,
    output logic [`STC_DAC_W-1:0]       dacData
);

    import stcPkg::*;

    sampleT     selected;

    //**********************************************************
    // Source select
    //**********************************************************
    always_ff @(posedge clk) begin
        if (reset) begin
            selected <= '0;
        end else begin
            case (regs.source)
                srcDemod: selected <= demodSample;
                srcStc:   selected <= stcSample;
                srcAdc:   selected <= adcSample;
                default:  selected <= '{valid: 1'b1, data: regs.testValue};
            endcase
        end
    end

    // Signed to offset binary, top bits only
    always_ff @(posedge clk) begin
        if (reset) begin
            dacData <= {1'b1, {(`STC_DAC_W-1){1'b0}}};    // Mid scale
        end else if (selected.valid) begin
            dacData <= {~selected.data[`STC_SAMPLE_W-1],
                        selected.data[`STC_SAMPLE_W-2 -: `STC_DAC_W-1]};
        end
    end

endmodule

`default_nettype wire

// ==== samplePath.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "stc_params.svh"

module samplePath (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`STC_ADC_W-1:0]       adc0,
    input  stcPkg::sampleT              demodSample0,
    input  stcPkg::sampleT              demodSample1,
    input  stcPkg::sampleT              stcSample0,
    input  stcPkg::sampleT              stcSample1,
    input  stcPkg::dacRegsT             dac0Regs,
    input  stcPkg::dacRegsT             dac1Regs,
    output logic [`STC_DAC_W-1:0]       dac0Data,
    output logic [`STC_DAC_W-1:0]       dac1Data
);

    import stcPkg::*;

    logic [`STC_ADC_W-1:0]              adcReg;
    logic signed [`STC_SAMPLE_W-1:0]    adcData;
    sampleT                             adcSample;

    //**********************************************************
    // ADC reclock
    //**********************************************************
    always_ff @(posedge clk) begin
        adcReg  <= adc0;
        adcData <= $signed({~adcReg[`STC_ADC_W-1], adcReg[`STC_ADC_W-2:0],
                            {`STC_PAD_W{1'b0}}});     // Offset binary to two's complement
    end

    assign adcSample = '{valid: 1'b1, data: adcData};   // New word every clock

    dacChannel u_dac0 (.clk(clk), .reset(reset), .regs(dac0Regs),
        .demodSample(demodSample0), .stcSample(stcSample0),
        .adcSample(adcSample), .dacData(dac0Data));

    dacChannel u_dac1 (.clk(clk), .reset(reset), .regs(dac1Regs),
        .demodSample(demodSample1), .stcSample(stcSample1),
        .adcSample(adcSample), .dacData(dac1Data));

endmodule

`default_nettype wire

// ==== readMux.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "stc_params.svh"

module readMux (
    input  logic                        clk,
    input  logic                        reset,
    input  stcPkg::busAccessT           access,
    input  logic [`STC_DATA_W-1:0]      topRead,
    input  logic [`STC_DATA_W-1:0]      dac0Read,
    input  logic [`STC_DATA_W-1:0]      dac1Read,
    output logic [`STC_DATA_W-1:0]      wbDatR
);

    import stcPkg::*;

    // Loaded on the ack edge, held otherwise
    always_ff @(posedge clk) begin
        if (reset) begin
            wbDatR <= '0;
        end else if (access.strobe && !access.write) begin
            case (access.space)
                spaceTop:  wbDatR <= topRead;
                spaceDac0: wbDatR <= dac0Read;
                spaceDac1: wbDatR <= dac1Read;
                default:   wbDatR <= '0;    // Unmapped
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== stcDemodTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "stc_params.svh"

module stcDemodTop (
    input  logic                        clk,
    input  logic                        reset,

    // Wishbone classic slave
    input  logic                        wbCyc,
    input  logic                        wbStb,
    input  logic                        wbWe,
    input  logic [`STC_ADDR_W-1:0]      wbAdr,
    input  logic [`STC_DATA_W-1:0]      wbDatW,
    input  logic [1:0]                  wbSel,
    output logic [`STC_DATA_W-1:0]      wbDatR,
    output logic                        wbAck,

    // Sample streams
    input  logic [`STC_ADC_W-1:0]       adc0,
    input  stcPkg::sampleT              demodSample0,
    input  stcPkg::sampleT              demodSample1,
    input  stcPkg::sampleT              stcSample0,
    input  stcPkg::sampleT              stcSample1,
    input  logic                        pilotFound,
    input  logic                        pilotLocked,

    output logic [`STC_DAC_W-1:0]       dac0Data,
    output logic [`STC_DAC_W-1:0]       dac1Data,
    output logic                        lockLed0n,
    output logic                        lockLed1n
);

    import stcPkg::*;

    busAccessT                  access;
    logic [`STC_DATA_W-1:0]     topRead;
    logic [`STC_DATA_W-1:0]     dac0Read;
    logic [`STC_DATA_W-1:0]     dac1Read;
    dacRegsT                    dac0Regs;
    dacRegsT                    dac1Regs;

    busDecode u_bus (.clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb),
        .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbSel(wbSel),
        .wbAck(wbAck), .access(access));

    configRegs u_regs (.clk(clk), .reset(reset), .access(access),
        .pilotFound(pilotFound), .pilotLocked(pilotLocked), .topRead(topRead),
        .dac0Read(dac0Read), .dac1Read(dac1Read), .dac0Regs(dac0Regs),
        .dac1Regs(dac1Regs), .lockLed0n(lockLed0n), .lockLed1n(lockLed1n));

    samplePath u_samples (.clk(clk), .reset(reset), .adc0(adc0),
        .demodSample0(demodSample0), .demodSample1(demodSample1),
        .stcSample0(stcSample0), .stcSample1(stcSample1),
        .dac0Regs(dac0Regs), .dac1Regs(dac1Regs),
        .dac0Data(dac0Data), .dac1Data(dac1Data));

    readMux u_rdMux (.clk(clk), .reset(reset), .access(access), .topRead(topRead),
        .dac0Read(dac0Read), .dac1Read(dac1Read), .wbDatR(wbDatR));

endmodule

`default_nettype wire

// ==== tbChecks.svh ====
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

//**********************************************************
// Wishbone master tasks, called just after a falling edge
//**********************************************************
task automatic wbWrite(input logic [`STC_ADDR_W-1:0] adr,
                       input logic [`STC_DATA_W-1:0] data,
                       input logic [1:0] sel);
    int waited;
    waited = 0;
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b1;
    wbAdr  = adr;
    wbDatW = data;
    wbSel  = sel;
    @(negedge clk);
    while (!wbAck && waited < ackTimeout) begin
        @(negedge clk);
        waited++;
    end
    if (!wbAck) begin
        $display("Write to address %h was not acknowledged within %0d cycles",
                 adr, ackTimeout);
        errorCount++;
    end
    wbCyc = 1'b0;   // Drop the request in the ack cycle
    wbStb = 1'b0;
    wbWe  = 1'b0;
endtask

task automatic wbRead(input logic [`STC_ADDR_W-1:0] adr,
                      output logic [`STC_DATA_W-1:0] data);
    int waited;
    waited = 0;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    wbWe  = 1'b0;
    wbAdr = adr;
    wbSel = 2'b11;
    @(negedge clk);
    while (!wbAck && waited < ackTimeout) begin
        @(negedge clk);
        waited++;
    end
    data = wbDatR;      // Valid while ack is high
    if (!wbAck) begin
        $display("Read from address %h was not acknowledged within %0d cycles",
                 adr, ackTimeout);
        errorCount++;
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
endtask

//**********************************************************
// Compare tasks
//**********************************************************
task automatic checkBusWord(input string name, input logic [`STC_DATA_W-1:0] actual,
                            input logic [`STC_DATA_W-1:0] expected);
    checkCount++;
    if (actual !== expected) begin
        $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        errorCount++;
    end
endtask

task automatic checkDacWord(input string name, input logic [`STC_DAC_W-1:0] actual,
                            input logic [`STC_DAC_W-1:0] expected);
    checkCount++;
    if (actual !== expected) begin
        $display("[ERROR] t=%0t %s: got %h, expected %h", $time, name, actual, expected);
        errorCount++;
    end
endtask

task automatic checkLed(input string name, input logic actual, input logic expected);
    checkCount++;
    if (actual !== expected) begin
        $display("[ERROR] t=%0t %s: got %b, expected %b", $time, name, actual, expected);
        errorCount++;
    end
endtask

`endif

// ==== tbStcDemodTop.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "stc_params.svh"

module tbStcDemodTop;

    import stcPkg::*;

    localparam int ackTimeout    = 16;
    localparam int settleTimeout = 16;

    logic                       clk;
    logic                       reset;
    logic                       wbCyc;
    logic                       wbStb;
    logic                       wbWe;
    logic [`STC_ADDR_W-1:0]     wbAdr;
    logic [`STC_DATA_W-1:0]     wbDatW;
    logic [1:0]                 wbSel;
    logic [`STC_DATA_W-1:0]     wbDatR;
    logic                       wbAck;
    logic [`STC_ADC_W-1:0]      adc0;
    sampleT                     demodSample0;
    sampleT                     demodSample1;
    sampleT                     stcSample0;
    sampleT                     stcSample1;
    logic                       pilotFound;
    logic                       pilotLocked;
    logic [`STC_DAC_W-1:0]      dac0Data;
    logic [`STC_DAC_W-1:0]      dac1Data;
    logic                       lockLed0n;
    logic                       lockLed1n;

    int             errorCount;
    int             checkCount;
    int             testCount;
    logic [31:0]    lfsrState;

    stcDemodTop u_dut (.clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb),
        .wbWe(wbWe), .wbAdr(wbAdr), .wbDatW(wbDatW), .wbSel(wbSel), .wbDatR(wbDatR),
        .wbAck(wbAck), .adc0(adc0), .demodSample0(demodSample0),
        .demodSample1(demodSample1), .stcSample0(stcSample0), .stcSample1(stcSample1),
        .pilotFound(pilotFound), .pilotLocked(pilotLocked), .dac0Data(dac0Data),
        .dac1Data(dac1Data), .lockLed0n(lockLed0n), .lockLed1n(lockLed1n));

    always #2 clk = ~clk;     // 4 ns period

    `include "tbChecks.svh"

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic logic [31:0] randomBits(input int width);
        logic [31:0]    bits;
        logic           feedback;
        bits = '0;
        for (int i = 0; i < width; i++) begin
            feedback  = lfsrState[31] ^ lfsrState[21] ^ lfsrState[1] ^ lfsrState[0];
            lfsrState = {lfsrState[30:0], feedback};
            bits      = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    function automatic logic [`STC_ADDR_W-1:0] regAddr(input logic [`STC_ADDR_W-1:0] base,
                                                      input logic [3:0] offset);
        return base | {{(`STC_ADDR_W-4){1'b0}}, offset};
    endfunction

    // Offset binary DAC word: sign flipped, then bits 16:4
    function automatic logic [`STC_DAC_W-1:0] expectedDacWord(
        input logic signed [`STC_SAMPLE_W-1:0] s
    );
        return {~s[17], s[16:4]};
    endfunction

    task automatic waitDacWords(input logic [`STC_DAC_W-1:0] exp0,
                                input logic [`STC_DAC_W-1:0] exp1);
        int waited;
        waited = 0;
        while ((dac0Data !== exp0 || dac1Data !== exp1) && waited < settleTimeout) begin
            @(negedge clk);
            waited++;
        end
        if (dac0Data !== exp0 || dac1Data !== exp1) begin
            $display("DAC outputs did not settle within %0d cycles", settleTimeout);
            errorCount++;
        end
    endtask

    task automatic reportTest(input string name, input int errorsBefore);
        testCount++;
        $display("%s finished with %0d errors", name, errorCount - errorsBefore);
    endtask

    //**********************************************************
    // Directed tests
    //**********************************************************
    task automatic testResetState();
        int                         errorsBefore;
        logic [`STC_DATA_W-1:0]     data;
        errorsBefore = errorCount;
        checkDacWord("dac0Data", dac0Data, 14'h2000);   // Zero sample
        checkDacWord("dac1Data", dac1Data, 14'h2000);
        wbRead(regAddr(`STC_TOP_BASE, `REG_VERSION), data);
        checkBusWord("version", data, 24'd654);
        wbRead(regAddr(`STC_TOP_BASE, `REG_SCRATCH), data);
        checkBusWord("scratch", data, 24'd0);
        reportTest("reset state", errorsBefore);
    endtask

    task automatic testScratch();
        int                         errorsBefore;
        logic [31:0]                rnd;
        logic [`STC_DATA_W-1:0]     wdata;
        logic [`STC_DATA_W-1:0]     expected;
        logic [`STC_DATA_W-1:0]     data;
        errorsBefore = errorCount;
        expected = '0;
        for (int lanes = 0; lanes < 4; lanes++) begin
            rnd   = randomBits(`STC_DATA_W);
            wdata = rnd[`STC_DATA_W-1:0];
            wbWrite(regAddr(`STC_TOP_BASE, `REG_SCRATCH), wdata, lanes[1:0]);
            if (lanes[0]) expected[15:0] = wdata[15:0];
            if (lanes[1]) expected[23:16] = wdata[23:16];
            wbRead(regAddr(`STC_TOP_BASE, `REG_SCRATCH), data);
            checkBusWord("scratch", data, expected);
        end
        wbWrite(regAddr(`STC_TOP_BASE, `REG_VERSION), 24'hFFFFFF, 2'b11);
        wbRead(regAddr(`STC_TOP_BASE, `REG_VERSION), data);
        checkBusWord("version", data, 24'd654);
        // 0x120 lies outside every space
        wbWrite(13'h120, 24'hA5A5A5, 2'b11);
        wbRead(13'h120, data);
        checkBusWord("unmapped", data, 24'd0);
        reportTest("scratch and decode", errorsBefore);
    endtask

    task automatic testStatus();
        int                         errorsBefore;
        logic [31:0]                rnd;
        logic [`STC_DATA_W-1:0]     data;
        errorsBefore = errorCount;
        for (int i = 0; i < 8; i++) begin
            rnd = randomBits(2);
            pilotFound  = rnd[0];
            pilotLocked = rnd[1];
            wbRead(regAddr(`STC_TOP_BASE, `REG_STATUS), data);
            checkBusWord("status", data, {{(`STC_DATA_W-2){1'b0}}, rnd[1], rnd[0]});
            checkLed("lockLed0n", lockLed0n, ~rnd[0]);   // Active low
            checkLed("lockLed1n", lockLed1n, ~rnd[1]);
        end
        reportTest("status and LEDs", errorsBefore);
    endtask

    task automatic testAdcLoopback();
        int                         errorsBefore;
        logic [31:0]                rnd;
        logic [`STC_DAC_W-1:0]      history [$];
        errorsBefore = errorCount;
        wbWrite(regAddr(`STC_DAC0_BASE, `REG_SOURCE), 24'(srcAdc), 2'b11);
        for (int i = 0; i < 36; i++) begin
            if (i >= 4)
                checkDacWord("dac0Data", dac0Data, history[i-4]);  // Four cycles late
            if (i < 32) begin
                rnd  = randomBits(`STC_ADC_W);
                adc0 = rnd[`STC_ADC_W-1:0];
                history.push_back(rnd[`STC_DAC_W-1:0]);
            end
            @(negedge clk);
        end
        reportTest("ADC loopback", errorsBefore);
    endtask

    task automatic testTestValue();
        int                                 errorsBefore;
        logic [31:0]                        rnd;
        logic signed [`STC_SAMPLE_W-1:0]    tv0;
        logic signed [`STC_SAMPLE_W-1:0]    tv1;
        logic [`STC_DATA_W-1:0]             data;
        errorsBefore = errorCount;
        rnd = randomBits(`STC_SAMPLE_W);
        tv0 = rnd[`STC_SAMPLE_W-1:0];
        rnd = randomBits(`STC_SAMPLE_W);
        tv1 = rnd[`STC_SAMPLE_W-1:0];
        wbWrite(regAddr(`STC_DAC0_BASE, `REG_SOURCE), 24'(srcTest), 2'b11);
        wbWrite(regAddr(`STC_DAC0_BASE, `REG_TEST), {6'b0, tv0}, 2'b11);
        wbWrite(regAddr(`STC_DAC1_BASE, `REG_TEST), {6'b0, tv1}, 2'b11);
        waitDacWords(expectedDacWord(tv0), expectedDacWord(tv1));
        checkDacWord("dac0Data", dac0Data, expectedDacWord(tv0));
        checkDacWord("dac1Data", dac1Data, expectedDacWord(tv1));
        wbRead(regAddr(`STC_DAC1_BASE, `REG_TEST), data);
        checkBusWord("dac1 test", data, {{(`STC_DATA_W-`STC_SAMPLE_W){tv1[17]}}, tv1});
        reportTest("test value", errorsBefore);
    endtask

    task automatic testStreams();
        int                         errorsBefore;
        logic [31:0]                rnd;
        sampleT                     streams [4];    // demod0, demod1, stc0, stc1
        logic [`STC_DAC_W-1:0]      exp0;
        logic [`STC_DAC_W-1:0]      exp1;
        errorsBefore = errorCount;
        for (int pass = 0; pass < 2; pass++) begin
            // Channels take opposite stream kinds, swapped on the second pass
            wbWrite(regAddr(`STC_DAC0_BASE, `REG_SOURCE),
                    (pass == 0) ? 24'(srcDemod) : 24'(srcStc), 2'b11);
            wbWrite(regAddr(`STC_DAC1_BASE, `REG_SOURCE),
                    (pass == 0) ? 24'(srcStc) : 24'(srcDemod), 2'b11);
            for (int k = 0; k < 4; k++) begin
                rnd = randomBits(`STC_SAMPLE_W);
                streams[k] = '{valid: 1'b1, data: rnd[`STC_SAMPLE_W-1:0]};
            end
            demodSample0 = streams[0];
            demodSample1 = streams[1];
            stcSample0   = streams[2];
            stcSample1   = streams[3];
            exp0 = expectedDacWord((pass == 0) ? streams[0].data : streams[2].data);
            exp1 = expectedDacWord((pass == 0) ? streams[3].data : streams[1].data);
            waitDacWords(exp0, exp1);
            checkDacWord("dac0Data", dac0Data, exp0);
            checkDacWord("dac1Data", dac1Data, exp1);
            for (int k = 0; k < 4; k++) begin
                rnd = randomBits(`STC_SAMPLE_W);
                streams[k] = '{valid: 1'b0, data: rnd[`STC_SAMPLE_W-1:0]};
            end
            demodSample0 = streams[0];
            demodSample1 = streams[1];
            stcSample0   = streams[2];
            stcSample1   = streams[3];
            for (int i = 0; i < 6; i++) begin
                @(negedge clk);
                checkDacWord("dac0Data", dac0Data, exp0);   // Held on invalid data
                checkDacWord("dac1Data", dac1Data, exp1);
            end
        end
        reportTest("stream sources", errorsBefore);
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        wbCyc        = 1'b0;
        wbStb        = 1'b0;
        wbWe         = 1'b0;
        wbAdr        = '0;
        wbDatW       = '0;
        wbSel        = '0;
        adc0         = '0;
        demodSample0 = '0;
        demodSample1 = '0;
        stcSample0   = '0;
        stcSample1   = '0;
        pilotFound   = 1'b0;
        pilotLocked  = 1'b0;
        errorCount   = 0;
        checkCount   = 0;
        testCount    = 0;
        lfsrState    = 32'd81339;
        repeat (5) @(negedge clk);
        reset = 1'b0;
        testResetState();
        testScratch();
        testStatus();
        testAdcLoopback();
        testTestValue();
        testStreams();
        $display("Tests: %0d, checks: %0d, errors: %0d", testCount, checkCount, errorCount);
        if (errorCount == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+.
stcPkg.sv
busDecode.sv
configRegs.sv
dacChannel.sv
samplePath.sv
readMux.sv
stcDemodTop.sv
tbStcDemodTop.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tbStcDemodTop
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST)) stc_params.svh tbChecks.svh
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@if grep -q "TEST RESULT: FAIL" $(LOG); then exit 1; fi
	@grep -q "TEST RESULT: PASS" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
